// ==== hw/controller_pkg.sv ====
// HCI command descriptor layout and response word encoding, imported by the flow FSM
`default_nettype none

package controller_pkg;

  // Command attribute codes
  localparam logic [1:0] CmdAttrRegular = 2'd0;
  localparam logic [1:0] CmdAttrImmed   = 2'd1;

  // One descriptor word, read as regular or immediate depending on attr
  typedef union packed {
    struct packed {
      logic [1:0] attr;
      logic [3:0] tid;
      logic       rnw;
      logic [6:0] addr;
      logic [7:0] data_len;
      logic [9:0] reserved;
    } regular;
    struct packed {
      logic [1:0] attr;
      logic [3:0] tid;
      logic [1:0] byte_cnt;
      logic [6:0] addr;
      logic [7:0] data0;
      logic [7:0] data1;
      logic       reserved;
    } immed;
  } hci_cmd_t;

  // Response word field positions
  localparam int unsigned RespStatusLsb = 28;
  localparam int unsigned RespTidLsb    = 24;
  localparam int unsigned RespLenLsb    = 0;

  localparam logic [3:0] StatusOk       = 4'd0;
  localparam logic [3:0] StatusAddrNack = 4'd1;
  localparam logic [3:0] StatusDataNack = 4'd2;
  localparam logic [3:0] StatusBadAttr  = 4'd3;

endpackage

`default_nettype wire

// ==== hw/i2c_pkg.sv ====
// Format entry flags and I2C bus levels shared by the flow FSM and the bit-level controller
`default_nettype none

package i2c_pkg;

  // Format entry flag positions
  localparam int unsigned FmtFlagWidth   = 5;
  localparam int unsigned FmtStartBefore = 0;
  localparam int unsigned FmtStopAfter   = 1;
  localparam int unsigned FmtReadByte    = 2;
  localparam int unsigned FmtReadLast    = 3;
  localparam int unsigned FmtStopOnly    = 4;

  // R/W bit after the 7-bit address
  localparam logic AddrWrite = 1'b0;
  localparam logic AddrRead  = 1'b1;

  // Open-drain levels
  localparam logic BusRelease = 1'b1;
  localparam logic SdaAck     = 1'b0;
  localparam logic SdaNack    = 1'b1;

endpackage

`default_nettype wire

// ==== hw/flow_active.sv ====
// Command flow FSM: pops HCI descriptors, issues I2C format entries and writes one response each
`timescale 1ns/100ps
`default_nettype none

module flow_active (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             fsm_en_i,
  output logic                             idle_o,
  input  logic                             cmd_queue_rvalid_i,
  output logic                             cmd_queue_rready_o,
  input  logic [31:0]                      cmd_queue_rdata_i,
  input  logic                             tx_queue_rvalid_i,
  output logic                             tx_queue_rready_o,
  input  logic [7:0]                       tx_queue_rdata_i,
  output logic                             rx_queue_wvalid_o,
  input  logic                             rx_queue_wready_i,
  output logic [7:0]                       rx_queue_wdata_o,
  output logic                             resp_queue_wvalid_o,
  input  logic                             resp_queue_wready_i,
  output logic [31:0]                      resp_queue_wdata_o,
  output logic                             fmt_valid_o,
  output logic [7:0]                       fmt_byte_o,
  output logic [i2c_pkg::FmtFlagWidth-1:0] fmt_flags_o,
  input  logic                             fmt_ready_i,
  input  logic                             byte_done_i,
  input  logic                             nak_i,
  input  logic [7:0]                       rx_byte_i
);
  import controller_pkg::*;
  import i2c_pkg::*;

  localparam logic [3:0] StIdle     = 4'd0;
  localparam logic [3:0] StDecode   = 4'd1;
  localparam logic [3:0] StAddr     = 4'd2;
  localparam logic [3:0] StAddrWait = 4'd3;
  localparam logic [3:0] StFetch    = 4'd4;
  localparam logic [3:0] StData     = 4'd5;
  localparam logic [3:0] StDataWait = 4'd6;
  localparam logic [3:0] StRxPush   = 4'd7;
  localparam logic [3:0] StStop     = 4'd8;
  localparam logic [3:0] StStopWait = 4'd9;
  localparam logic [3:0] StResp     = 4'd10;

  logic [3:0] state_q;
  hci_cmd_t   cmd_q;
  logic [7:0] len_q;
  logic [7:0] cnt_q;
  logic [3:0] status_q;
  logic [7:0] data_q;
  logic [7:0] rx_q;
  logic       is_immed;
  logic       is_read;
  logic       last_byte;
  logic [6:0] tgt_addr;

  // Field decode depends on which union member the attr selects
  assign is_immed  = cmd_q.immed.attr == CmdAttrImmed;
  assign is_read   = !is_immed && cmd_q.regular.rnw;
  assign tgt_addr  = is_immed ? cmd_q.immed.addr : cmd_q.regular.addr;
  assign last_byte = (cnt_q + 8'd1) == len_q;

  assign idle_o              = state_q == StIdle;
  assign cmd_queue_rready_o  = idle_o && fsm_en_i;
  assign tx_queue_rready_o   = (state_q == StFetch) && !is_immed;
  assign rx_queue_wvalid_o   = state_q == StRxPush;
  assign rx_queue_wdata_o    = rx_q;
  assign resp_queue_wvalid_o = state_q == StResp;

  always_comb begin
    resp_queue_wdata_o = '0;
    resp_queue_wdata_o[RespStatusLsb +: 4] = status_q;
    resp_queue_wdata_o[RespTidLsb +: 4]    = cmd_q.regular.tid;
    resp_queue_wdata_o[RespLenLsb +: 16]   = 16'(cnt_q);
  end

  assign fmt_valid_o = state_q inside {StAddr, StData, StStop};
  assign fmt_byte_o  = (state_q == StAddr) ? {tgt_addr, is_read ? AddrRead : AddrWrite} : data_q;

  always_comb begin
    fmt_flags_o = '0;
    case (state_q)
      StAddr: begin
        fmt_flags_o[FmtStartBefore] = 1'b1;
        fmt_flags_o[FmtStopAfter]   = len_q == 8'd0;
      end
      StData: begin
        fmt_flags_o[FmtStopAfter] = last_byte;
        fmt_flags_o[FmtReadByte]  = is_read;
        fmt_flags_o[FmtReadLast]  = is_read && last_byte;
      end
      StStop: fmt_flags_o[FmtStopOnly] = 1'b1;
      default: fmt_flags_o = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= StIdle;
      len_q    <= '0;
      cnt_q    <= '0;
      status_q <= StatusOk;
    end else begin
      case (state_q)
        StIdle: begin
          if (cmd_queue_rvalid_i && fsm_en_i) begin
            cnt_q    <= '0;
            status_q <= StatusOk;
            state_q  <= StDecode;
          end
        end
        StDecode: begin
          len_q <= is_immed ? 8'(cmd_q.immed.byte_cnt) : cmd_q.regular.data_len;
          if (cmd_q.regular.attr inside {CmdAttrRegular, CmdAttrImmed}) begin
            state_q <= StAddr;
          end else begin
            status_q <= StatusBadAttr;
            state_q  <= StResp;
          end
        end
        StAddr: if (fmt_ready_i) state_q <= StAddrWait;
        StAddrWait: begin
          if (byte_done_i) begin
            if (nak_i) begin
              status_q <= StatusAddrNack;
              // A zero-length entry already carried the STOP
              state_q  <= (len_q == 8'd0) ? StResp : StStop;
            end else if (len_q == 8'd0) begin
              state_q <= StResp;
            end else begin
              state_q <= is_read ? StData : StFetch;
            end
          end
        end
        StFetch: if (is_immed || tx_queue_rvalid_i) state_q <= StData;
        StData: if (fmt_ready_i) state_q <= StDataWait;
        StDataWait: begin
          if (byte_done_i) begin
            if (is_read) begin
              state_q <= StRxPush;
            end else if (nak_i) begin
              status_q <= StatusDataNack;
              state_q  <= last_byte ? StResp : StStop;
            end else begin
              cnt_q   <= cnt_q + 8'd1;
              state_q <= last_byte ? StResp : StFetch;
            end
          end
        end
        StRxPush: begin
          if (rx_queue_wready_i) begin
            cnt_q   <= cnt_q + 8'd1;
            state_q <= last_byte ? StResp : StData;
          end
        end
        StStop: if (fmt_ready_i) state_q <= StStopWait;
        StStopWait: if (byte_done_i) state_q <= StResp;
        StResp: if (resp_queue_wready_i) state_q <= StIdle;
        default: state_q <= StIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_queue_rready_o && cmd_queue_rvalid_i) begin
      cmd_q <= cmd_queue_rdata_i;
    end
    if (state_q == StFetch) begin
      if (is_immed) begin
        data_q <= (cnt_q == 8'd0) ? cmd_q.immed.data0 : cmd_q.immed.data1;
      end else begin
        data_q <= tx_queue_rdata_i;
      end
    end
    if ((state_q == StDataWait) && byte_done_i) begin
      rx_q <= rx_byte_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/i2c_controller_fsm.sv ====
// Bit-level I2C master that turns format entries into START, data, ACK and STOP on SCL/SDA
`timescale 1ns/100ps
`default_nettype none

module i2c_controller_fsm #(
  parameter int unsigned ClkDiv = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             scl_i,
  input  logic                             sda_i,
  output logic                             scl_o,
  output logic                             sda_o,
  input  logic                             fmt_valid_i,
  input  logic [7:0]                       fmt_byte_i,
  input  logic [i2c_pkg::FmtFlagWidth-1:0] fmt_flags_i,
  output logic                             fmt_ready_o,
  output logic                             byte_done_o,
  output logic                             nak_o,
  output logic [7:0]                       rx_byte_o
);
  import i2c_pkg::*;

  localparam int unsigned DivWidth = $clog2(ClkDiv + 1);
  localparam logic [DivWidth-1:0] DivLast = DivWidth'(ClkDiv - 1);

  localparam logic [2:0] StIdle  = 3'd0;
  localparam logic [2:0] StStart = 3'd1;
  localparam logic [2:0] StBits  = 3'd2;
  localparam logic [2:0] StAck   = 3'd3;
  localparam logic [2:0] StTail  = 3'd4;

  logic [2:0]              state_q;
  logic [1:0]              qtr_q;
  logic [DivWidth-1:0]     div_q;
  logic [2:0]              bit_q;
  logic                    scl_q;
  logic                    sda_q;
  logic                    done_q;
  logic                    nak_q;
  logic [7:0]              shift_q;
  logic [FmtFlagWidth-1:0] flags_q;
  logic                    tick;
  logic                    is_read;
  logic                    do_stop;

  // Quarter tick only once the bus has followed the driven SCL level
  assign tick    = (div_q == DivLast) && (scl_i == scl_q);
  assign is_read = flags_q[FmtReadByte];
  assign do_stop = flags_q[FmtStopAfter] || flags_q[FmtStopOnly];

  assign fmt_ready_o = (state_q == StIdle) && fmt_valid_i;
  assign scl_o       = scl_q;
  assign sda_o       = sda_q;
  assign byte_done_o = done_q;
  assign nak_o       = nak_q;
  assign rx_byte_o   = shift_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
      qtr_q   <= '0;
      div_q   <= '0;
      bit_q   <= '0;
      scl_q   <= BusRelease;
      sda_q   <= BusRelease;
      done_q  <= 1'b0;
      nak_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (state_q == StIdle) begin
        // SCL stays where the last entry left it
        div_q <= '0;
        qtr_q <= '0;
        if (fmt_ready_o) begin
          bit_q <= 3'd7;
          nak_q <= 1'b0;
          if (fmt_flags_i[FmtStopOnly]) begin
            state_q <= StTail;
          end else if (fmt_flags_i[FmtStartBefore]) begin
            state_q <= StStart;
          end else begin
            state_q <= StBits;
          end
        end
      end else if (tick) begin
        div_q <= '0;
        qtr_q <= qtr_q + 2'd1;
        case (state_q)
          StStart: begin
            case (qtr_q)
              2'd0: sda_q <= BusRelease;
              2'd1: scl_q <= BusRelease;
              2'd2: sda_q <= 1'b0;
              default: state_q <= StBits;
            endcase
          end
          StBits: begin
            case (qtr_q)
              2'd0: scl_q <= 1'b0;
              2'd1: sda_q <= is_read ? BusRelease : shift_q[7];
              2'd2: scl_q <= BusRelease;
              default: begin
                bit_q <= bit_q - 3'd1;
                if (bit_q == 3'd0) state_q <= StAck;
              end
            endcase
          end
          StAck: begin
            case (qtr_q)
              2'd0: scl_q <= 1'b0;
              2'd1: begin
                if (is_read) begin
                  sda_q <= flags_q[FmtReadLast] ? SdaNack : SdaAck;
                end else begin
                  sda_q <= BusRelease;
                end
              end
              2'd2: scl_q <= BusRelease;
              default: begin
                if (!is_read) nak_q <= sda_i == SdaNack;
                state_q <= StTail;
              end
            endcase
          end
          StTail: begin
            // Pull SCL low, then optionally a STOP
            case (qtr_q)
              2'd0: begin
                scl_q <= 1'b0;
                if (!do_stop) begin
                  done_q  <= 1'b1;
                  state_q <= StIdle;
                end
              end
              2'd1: sda_q <= 1'b0;
              2'd2: scl_q <= BusRelease;
              default: begin
                sda_q   <= BusRelease;
                done_q  <= 1'b1;
                state_q <= StIdle;
              end
            endcase
          end
          default: state_q <= StIdle;
        endcase
      end else if (div_q != DivLast) begin
        div_q <= div_q + 1'b1;
      end
    end
  end

  // Shift register serves both directions, MSB first
  always_ff @(posedge clk_i) begin
    if (fmt_ready_o) begin
      shift_q <= fmt_byte_i;
      flags_q <= fmt_flags_i;
    end else if ((state_q == StBits) && tick && (qtr_q == 2'd3)) begin
      shift_q <= {shift_q[6:0], sda_i};
    end
  end

endmodule

`default_nettype wire

// ==== hw/controller_active.sv ====
// Active-mode I2C host top: joins the command flow FSM to the bit-level bus controller
`timescale 1ns/100ps
`default_nettype none

module controller_active #(
  parameter int unsigned ClkDiv = 4
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        fsm_en_i,
  output logic        idle_o,
  input  logic        cmd_queue_rvalid_i,
  output logic        cmd_queue_rready_o,
  input  logic [31:0] cmd_queue_rdata_i,
  input  logic        tx_queue_rvalid_i,
  output logic        tx_queue_rready_o,
  input  logic [7:0]  tx_queue_rdata_i,
  output logic        rx_queue_wvalid_o,
  input  logic        rx_queue_wready_i,
  output logic [7:0]  rx_queue_wdata_o,
  output logic        resp_queue_wvalid_o,
  input  logic        resp_queue_wready_i,
  output logic [31:0] resp_queue_wdata_o,
  input  logic        scl_i,
  input  logic        sda_i,
  output logic        scl_o,
  output logic        sda_o
);
  import i2c_pkg::*;

  // Format entry link
  logic                    fmt_valid;
  logic [7:0]              fmt_byte;
  logic [FmtFlagWidth-1:0] fmt_flags;
  logic                    fmt_ready;
  logic                    byte_done;
  logic                    nak;
  logic [7:0]              rx_byte;

  flow_active u_flow (
    .clk_i,
    .rst_n_i,
    .fsm_en_i,
    .idle_o,
    .cmd_queue_rvalid_i,
    .cmd_queue_rready_o,
    .cmd_queue_rdata_i,
    .tx_queue_rvalid_i,
    .tx_queue_rready_o,
    .tx_queue_rdata_i,
    .rx_queue_wvalid_o,
    .rx_queue_wready_i,
    .rx_queue_wdata_o,
    .resp_queue_wvalid_o,
    .resp_queue_wready_i,
    .resp_queue_wdata_o,
    .fmt_valid_o (fmt_valid),
    .fmt_byte_o  (fmt_byte),
    .fmt_flags_o (fmt_flags),
    .fmt_ready_i (fmt_ready),
    .byte_done_i (byte_done),
    .nak_i       (nak),
    .rx_byte_i   (rx_byte)
  );

  i2c_controller_fsm #(
    .ClkDiv(ClkDiv)
  ) u_i2c_fsm (
    .clk_i,
    .rst_n_i,
    .scl_i,
    .sda_i,
    .scl_o,
    .sda_o,
    .fmt_valid_i (fmt_valid),
    .fmt_byte_i  (fmt_byte),
    .fmt_flags_i (fmt_flags),
    .fmt_ready_o (fmt_ready),
    .byte_done_o (byte_done),
    .nak_o       (nak),
    .rx_byte_o   (rx_byte)
  );

endmodule

`default_nettype wire

// ==== sim/i2c_target_model.sv ====
// Behavioral I2C target for the testbench, sampling the wired-AND bus on the system clock
`timescale 1ns/100ps
`default_nettype none

module i2c_target_model #(
  parameter logic [6:0]  OwnAddr   = 7'h2A,
  parameter int unsigned MaxWrites = 6
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic sda_o
);
  localparam logic [1:0] StIdle  = 2'd0;
  localparam logic [1:0] StAddr  = 2'd1;
  localparam logic [1:0] StWrite = 2'd2;
  localparam logic [1:0] StRead  = 2'd3;

  // Written bytes in arrival order, read by the testbench
  logic [7:0]  wr_mem [0:63];
  int unsigned wr_cnt;

  logic [1:0]  state_q;
  logic        scl_q;
  logic        sda_q;
  logic [3:0]  bit_cnt;
  logic [7:0]  shift_q;
  logic [7:0]  rd_idx;
  logic        rnw_q;
  logic        mst_nack_q;
  int unsigned acked_q;
  logic [7:0]  rd_byte;
  logic [7:0]  rd_next;

  assign rd_byte = 8'hA0 + rd_idx;
  assign rd_next = rd_byte + 8'd1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= StIdle;
      scl_q      <= 1'b1;
      sda_q      <= 1'b1;
      sda_o      <= 1'b1;
      bit_cnt    <= '0;
      rd_idx     <= '0;
      rnw_q      <= 1'b0;
      mst_nack_q <= 1'b0;
      acked_q    <= 0;
      wr_cnt     <= 0;
    end else begin
      scl_q <= scl_i;
      sda_q <= sda_i;
      if (scl_q && scl_i && sda_q && !sda_i) begin
        // START
        state_q <= StAddr;
        bit_cnt <= '0;
        acked_q <= 0;
        rd_idx  <= '0;
        sda_o   <= 1'b1;
      end else if (scl_q && scl_i && !sda_q && sda_i) begin
        state_q <= StIdle;
        sda_o   <= 1'b1;
      end else if (state_q != StIdle) begin
        if (!scl_q && scl_i) begin
          if (bit_cnt < 4'd8) begin
            shift_q <= {shift_q[6:0], sda_i};
          end else begin
            mst_nack_q <= sda_i;
          end
          bit_cnt <= bit_cnt + 4'd1;
        end else if (scl_q && !scl_i) begin
          if (bit_cnt == 4'd8) begin
            // Eight bits in, decide the ACK slot
            case (state_q)
              StAddr: begin
                if (shift_q[7:1] == OwnAddr) begin
                  sda_o <= 1'b0;
                  rnw_q <= shift_q[0];
                end else begin
                  state_q <= StIdle;
                end
              end
              StWrite: begin
                if (acked_q < MaxWrites) begin
                  sda_o          <= 1'b0;
                  wr_mem[wr_cnt] <= shift_q;
                  wr_cnt         <= wr_cnt + 1;
                  acked_q        <= acked_q + 1;
                end
              end
              default: sda_o <= 1'b1;
            endcase
          end else if (bit_cnt == 4'd9) begin
            bit_cnt <= '0;
            if (state_q == StAddr) begin
              state_q <= rnw_q ? StRead : StWrite;
              sda_o   <= rnw_q ? rd_byte[7] : 1'b1;
            end else if (state_q == StRead) begin
              if (mst_nack_q) begin
                sda_o   <= 1'b1;
                state_q <= StIdle;
              end else begin
                rd_idx <= rd_idx + 8'd1;
                sda_o  <= rd_next[7];
              end
            end else begin
              sda_o <= 1'b1;
            end
          end else if ((state_q == StRead) && (bit_cnt != 4'd0)) begin
            sda_o <= rd_byte[4'd7 - bit_cnt];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/controller_active_tb.sv ====
// Directed testbench for the active-mode I2C host, run from build.f with an I2C target model
`timescale 1ns/100ps
`default_nettype none

module controller_active_tb;
  import controller_pkg::*;

  localparam int unsigned ClkDiv = 4;
  // About 35 bus bytes over all tests, plus room for RX back-pressure
  localparam int unsigned ByteCycles = 10 * 4 * ClkDiv;
  localparam int unsigned MaxCycles  = 125 * ByteCycles;

  logic        clk;
  logic        rst_n;
  logic        fsm_en;
  logic        idle;
  logic        cmd_valid;
  logic        cmd_ready;
  logic [31:0] cmd_data;
  logic        tx_valid = 1'b0;
  logic        tx_ready;
  logic [7:0]  tx_data = 8'h00;
  logic        rx_valid;
  logic        rx_ready = 1'b1;
  logic [7:0]  rx_data;
  logic        resp_valid;
  logic        resp_ready;
  logic [31:0] resp_data;
  logic        scl_drv;
  logic        sda_drv;
  logic        tgt_sda;
  logic        scl_bus;
  logic        sda_bus;

  logic [7:0]  tx_mem [0:63];
  int unsigned tx_wr = 0;
  int unsigned tx_rd = 0;
  int unsigned tx_ready_cycles = 0;
  logic [7:0]  rx_q [$];
  logic        rx_throttle = 1'b0;
  logic        rx_pattern [0:255];
  int unsigned cycle_cnt = 0;
  int unsigned err_cnt = 0;
  int unsigned pass_cnt = 0;
  int unsigned fail_cnt = 0;

  // Open-drain bus, the target never stretches SCL
  assign scl_bus = scl_drv;
  assign sda_bus = sda_drv & tgt_sda;

  controller_active #(
    .ClkDiv(ClkDiv)
  ) u_controller_active (
    .clk_i               (clk),
    .rst_n_i             (rst_n),
    .fsm_en_i            (fsm_en),
    .idle_o              (idle),
    .cmd_queue_rvalid_i  (cmd_valid),
    .cmd_queue_rready_o  (cmd_ready),
    .cmd_queue_rdata_i   (cmd_data),
    .tx_queue_rvalid_i   (tx_valid),
    .tx_queue_rready_o   (tx_ready),
    .tx_queue_rdata_i    (tx_data),
    .rx_queue_wvalid_o   (rx_valid),
    .rx_queue_wready_i   (rx_ready),
    .rx_queue_wdata_o    (rx_data),
    .resp_queue_wvalid_o (resp_valid),
    .resp_queue_wready_i (resp_ready),
    .resp_queue_wdata_o  (resp_data),
    .scl_i               (scl_bus),
    .sda_i               (sda_bus),
    .scl_o               (scl_drv),
    .sda_o               (sda_drv)
  );

  i2c_target_model #(
    .OwnAddr   (7'h2A),
    .MaxWrites (6)
  ) u_target (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .scl_i   (scl_bus),
    .sda_i   (sda_bus),
    .sda_o   (tgt_sda)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("Timeout: run did not finish within %0d cycles", MaxCycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // TX queue model
  always @(posedge clk) begin
    if (tx_valid && tx_ready) begin
      tx_rd    <= tx_rd + 1;
      tx_valid <= (tx_rd + 1) < tx_wr;
      tx_data  <= tx_mem[tx_rd + 1];
    end else begin
      tx_valid <= tx_rd < tx_wr;
      tx_data  <= tx_mem[tx_rd];
    end
    if (tx_ready) begin
      tx_ready_cycles <= tx_ready_cycles + 1;
    end
  end

  // RX queue model; when throttled, every new byte meets at least one stall
  always @(posedge clk) begin
    if (rx_valid && rx_ready) begin
      rx_q.push_back(rx_data);
    end
    rx_ready <= rx_throttle ? (rx_valid && rx_pattern[cycle_cnt % 256]) : 1'b1;
  end

  function automatic logic [7:0] tx_byte(input logic [7:0] first, input int unsigned idx);
    return first + 8'(idx * 37);
  endfunction

  task automatic check_resp(input logic [31:0] got, input logic [3:0] status,
                            input logic [3:0] tid, input logic [15:0] len, input string what);
    logic [31:0] exp;
    exp = '0;
    exp[RespStatusLsb +: 4] = status;
    exp[RespTidLsb +: 4]    = tid;
    exp[RespLenLsb +: 16]   = len;
    if (got !== exp) begin
      err_cnt = err_cnt + 1;
      $display("[ERROR] %0t: %s response %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      err_cnt = err_cnt + 1;
      $display("[ERROR] %0t: %s %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int unsigned got, input int unsigned exp, input string what);
    if (got != exp) begin
      err_cnt = err_cnt + 1;
      $display("[ERROR] %0t: %s %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_cnt = err_cnt + 1;
      $display("[ERROR] %0t: %s %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt = pass_cnt + 1;
      $display("[PASS] %s", name);
    end else begin
      fail_cnt = fail_cnt + 1;
      $display("[FAIL] %s: %0d mismatches", name, err_cnt - errs_before);
    end
  endtask

  // Called right after a rising edge
  task automatic push_cmd(input hci_cmd_t cmd);
    cmd_valid <= 1'b1;
    cmd_data  <= cmd;
    @(posedge clk);
    while (!cmd_ready) @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_resp(output logic [31:0] word, output int unsigned cycles);
    cycles = 1;
    @(posedge clk);
    while (!(resp_valid && resp_ready)) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    word = resp_data;
  endtask

  task automatic load_tx(input logic [7:0] first, input int unsigned n);
    int unsigned i;
    for (i = 0; i < n; i++) begin
      tx_mem[tx_wr + i] <= tx_byte(first, i);
    end
    tx_wr <= tx_wr + n;
  endtask

  task automatic test_idle_reset();
    hci_cmd_t    cmd;
    logic [31:0] resp;
    int unsigned cycles;
    int unsigned errs;
    int unsigned pops;
    errs = err_cnt;
    pops = 0;
    check_level(idle, 1'b1, "idle_o after reset");
    check_level(scl_drv, 1'b1, "scl_o after reset");
    check_level(sda_drv, 1'b1, "sda_o after reset");
    // Zero-length write held while the FSM is disabled
    cmd = '0;
    cmd.regular.attr = CmdAttrRegular;
    cmd.regular.tid  = 4'h6;
    cmd.regular.addr = 7'h2A;
    cmd_valid <= 1'b1;
    cmd_data  <= cmd;
    repeat (40) begin
      @(posedge clk);
      if (cmd_ready) pops = pops + 1;
    end
    check_count(pops, 0, "pops with fsm_en_i low");
    check_level(idle, 1'b1, "idle_o while disabled");
    fsm_en <= 1'b1;
    push_cmd(cmd);
    wait_resp(resp, cycles);
    check_resp(resp, StatusOk, 4'h6, 16'd0, "zero-length write");
    report_test("idle_reset", errs);
  endtask

  task automatic test_regular_write();
    hci_cmd_t    cmd;
    logic [31:0] resp;
    int unsigned cycles;
    int unsigned errs;
    int unsigned base;
    int unsigned pops;
    int unsigned i;
    errs = err_cnt;
    base = u_target.wr_cnt;
    pops = tx_rd;
    load_tx(8'h3C, 4);
    cmd = '0;
    cmd.regular.attr     = CmdAttrRegular;
    cmd.regular.tid      = 4'h1;
    cmd.regular.addr     = 7'h2A;
    cmd.regular.data_len = 8'd4;
    push_cmd(cmd);
    wait_resp(resp, cycles);
    check_resp(resp, StatusOk, 4'h1, 16'd4, "write of 4");
    check_count(tx_rd - pops, 4, "TX pops");
    check_count(u_target.wr_cnt - base, 4, "bytes at target");
    for (i = 0; i < 4; i++) begin
      check_byte(u_target.wr_mem[base + i], tx_byte(8'h3C, i), "target byte");
    end
    report_test("regular_write", errs);
  endtask

  task automatic test_regular_read();
    hci_cmd_t    cmd;
    logic [31:0] resp;
    int unsigned cycles;
    int unsigned errs;
    int unsigned i;
    errs = err_cnt;
    rx_q.delete();
    rx_throttle <= 1'b1;
    cmd = '0;
    cmd.regular.attr     = CmdAttrRegular;
    cmd.regular.tid      = 4'h2;
    cmd.regular.rnw      = 1'b1;
    cmd.regular.addr     = 7'h2A;
    cmd.regular.data_len = 8'd5;
    push_cmd(cmd);
    wait_resp(resp, cycles);
    rx_throttle <= 1'b0;
    check_resp(resp, StatusOk, 4'h2, 16'd5, "read of 5");
    check_count(rx_q.size(), 5, "RX bytes");
    for (i = 0; i < rx_q.size(); i++) begin
      check_byte(rx_q[i], 8'hA0 + 8'(i), "RX byte");
    end
    report_test("regular_read", errs);
  endtask

  task automatic test_immediate_write();
    hci_cmd_t    cmd;
    logic [31:0] resp;
    int unsigned cycles;
    int unsigned errs;
    int unsigned base;
    int unsigned ready0;
    errs   = err_cnt;
    base   = u_target.wr_cnt;
    ready0 = tx_ready_cycles;
    cmd = '0;
    cmd.immed.attr     = CmdAttrImmed;
    cmd.immed.tid      = 4'h3;
    cmd.immed.byte_cnt = 2'd2;
    cmd.immed.addr     = 7'h2A;
    cmd.immed.data0    = 8'hC3;
    cmd.immed.data1    = 8'h5E;
    push_cmd(cmd);
    wait_resp(resp, cycles);
    check_resp(resp, StatusOk, 4'h3, 16'd2, "immediate write");
    check_count(tx_ready_cycles - ready0, 0, "TX ready cycles");
    check_count(u_target.wr_cnt - base, 2, "bytes at target");
    check_byte(u_target.wr_mem[base], 8'hC3, "data0 at target");
    check_byte(u_target.wr_mem[base + 1], 8'h5E, "data1 at target");
    report_test("immediate_write", errs);
  endtask

  task automatic test_addr_nack();
    hci_cmd_t    cmd;
    logic [31:0] resp;
    int unsigned cycles;
    int unsigned errs;
    errs = err_cnt;
    rx_q.delete();
    cmd = '0;
    cmd.regular.attr     = CmdAttrRegular;
    cmd.regular.tid      = 4'h4;
    cmd.regular.rnw      = 1'b1;
    cmd.regular.addr     = 7'h33;
    cmd.regular.data_len = 8'd3;
    push_cmd(cmd);
    wait_resp(resp, cycles);
    check_resp(resp, StatusAddrNack, 4'h4, 16'd0, "address NACK");
    check_count(rx_q.size(), 0, "RX writes");
    check_level(scl_drv, 1'b1, "scl_o after NACK");
    check_level(sda_drv, 1'b1, "sda_o after NACK");
    report_test("addr_nack", errs);
  endtask

  task automatic test_data_nack();
    hci_cmd_t    cmd;
    logic [31:0] resp;
    int unsigned cycles;
    int unsigned errs;
    int unsigned base;
    int unsigned i;
    errs = err_cnt;
    base = u_target.wr_cnt;
    load_tx(8'h81, 8);
    cmd = '0;
    cmd.regular.attr     = CmdAttrRegular;
    cmd.regular.tid      = 4'h5;
    cmd.regular.addr     = 7'h2A;
    cmd.regular.data_len = 8'd8;
    push_cmd(cmd);
    wait_resp(resp, cycles);
    check_resp(resp, StatusDataNack, 4'h5, 16'd6, "data NACK");
    check_count(u_target.wr_cnt - base, 6, "bytes at target");
    for (i = 0; i < 6; i++) begin
      check_byte(u_target.wr_mem[base + i], tx_byte(8'h81, i), "target byte");
    end
    // Attribute 3 is unsupported
    cmd = '0;
    cmd.regular.attr = 2'd3;
    cmd.regular.tid  = 4'h7;
    push_cmd(cmd);
    wait_resp(resp, cycles);
    check_resp(resp, StatusBadAttr, 4'h7, 16'd0, "bad attribute");
    check_level(cycles <= 3, 1'b1, "bad attribute response within 3 cycles");
    check_level(scl_drv, 1'b1, "scl_o after bad attribute");
    check_level(sda_drv, 1'b1, "sda_o after bad attribute");
    report_test("data_nack", errs);
  endtask

  initial begin
    int unsigned seed;
    int i;
    seed = 32'h43f50d6f;
    void'($urandom(seed));
    for (i = 0; i < 256; i++) begin
      rx_pattern[i] = ($urandom % 4) != 0;
    end
    rst_n      <= 1'b0;
    fsm_en     <= 1'b0;
    cmd_valid  <= 1'b0;
    cmd_data   <= '0;
    resp_ready <= 1'b1;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    test_idle_reset();
    test_regular_write();
    test_regular_read();
    test_immediate_write();
    test_addr_nack();
    test_data_nack();
    $display("Summary: %0d passed, %0d failed, %0d mismatches", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
hw/controller_pkg.sv
hw/i2c_pkg.sv
hw/flow_active.sv
hw/i2c_controller_fsm.sv
hw/controller_active.sv
sim/i2c_target_model.sv
sim/controller_active_tb.sv
